/* logic/pet_config.svh */
`ifndef PET_CONFIG_SVH
`define PET_CONFIG_SVH

// Decay periods in clock cycles, one per need
`define PET_DECAY_HEALTH 121
`define PET_DECAY_ENERGY 101
`define PET_DECAY_HUNGER 71
`define PET_DECAY_FUN    51

// Level limits
`define PET_LEVEL_MAX   10
`define PET_LEVEL_START 8

// Lowest level that still shows a happy face
`define PET_HAPPY_MIN 5

`endif

/* logic/pet_pkg.sv */
package pet_pkg;

    localparam int NEED_COUNT = 4;  // Health, energy, hunger, fun

    // Which need is selected or addressed
    typedef enum logic [1:0] {
        NEED_HEALTH = 2'd0,
        NEED_ENERGY = 2'd1,
        NEED_HUNGER = 2'd2,
        NEED_FUN    = 2'd3
    } need_t;

    typedef logic [3:0] level_t;  // Need level, 0 to 10

    // All four levels side by side
    typedef struct packed {
        level_t health;
        level_t energy;
        level_t hunger;
        level_t fun;
    } levels_t;

    // Feed command from the button logic to the level bank
    typedef struct packed {
        logic  valid;   // One-cycle pulse
        need_t need;    // Need being fed
        logic  toggle;  // Test mode toggle instead of increment
    } feed_cmd_t;

endpackage

/* logic/display_pkg.sv */
package display_pkg;

    typedef logic [6:0] seg_t;  // Bit 0 is segment a, active high

    localparam seg_t SEG_BLANK = 7'b0000000;  // All segments off

    // Display output word
    typedef struct packed {
        logic           happy;  // Face, high when happy
        pet_pkg::need_t need;   // Need on display
        seg_t           seg;    // Digit of its level
    } status_t;

    // Level to seven-segment pattern, 10 shows as "A"
    function automatic seg_t level_to_seg(input pet_pkg::level_t level);
        case (level)
            4'd0:    level_to_seg = 7'b0111111;
            4'd1:    level_to_seg = 7'b0000110;
            4'd2:    level_to_seg = 7'b1011011;
            4'd3:    level_to_seg = 7'b1001111;
            4'd4:    level_to_seg = 7'b1100110;
            4'd5:    level_to_seg = 7'b1101101;
            4'd6:    level_to_seg = 7'b1111101;
            4'd7:    level_to_seg = 7'b0000111;
            4'd8:    level_to_seg = 7'b1111111;
            4'd9:    level_to_seg = 7'b1101111;
            4'd10:   level_to_seg = 7'b1110111;  // A
            default: level_to_seg = SEG_BLANK;   // Out of range
        endcase
    endfunction

endpackage

/* logic/need_select.sv */
`timescale 1ns/100ps

module need_select (
    input  logic               clk,
    input  logic               btn_reset,
    input  logic               btn_health,
    input  logic               btn_energy,
    input  logic               btn_hunger,
    input  logic               btn_fun,
    input  logic               btn_test,
    input  logic               sleep_ok,
    output pet_pkg::need_t     sel,
    output pet_pkg::feed_cmd_t cmd,
    output logic               test_mode
);
    import pet_pkg::*;

    logic  energy_ok;   // Energy strobe while the light is off
    logic  press;       // Some need strobe counts this cycle
    need_t press_need;  // Highest priority need pressed
    logic  feed;        // Press on the need already shown

    assign energy_ok = btn_energy && sleep_ok;

    // Priority is health, energy, hunger, fun
    always_comb begin
        press      = 1'b1;
        press_need = NEED_HEALTH;
        if (btn_health) begin
            press_need = NEED_HEALTH;
        end else if (energy_ok) begin
            press_need = NEED_ENERGY;
        end else if (btn_hunger) begin
            press_need = NEED_HUNGER;
        end else if (btn_fun) begin
            press_need = NEED_FUN;
        end else begin
            press = 1'b0;
        end
    end

    // Second press on the same need feeds it
    assign feed = press && (press_need == sel);

    always_ff @(posedge clk) begin
        cmd.need   <= press_need;  // Payload, qualified by valid
        cmd.toggle <= test_mode;
        if (btn_reset) begin
            sel       <= NEED_HEALTH;
            cmd.valid <= 1'b0;
            test_mode <= 1'b0;
        end else begin
            cmd.valid <= feed;  // Single-cycle pulse
            if (press) begin
                sel <= press_need;
            end
            if (btn_test) begin
                test_mode <= 1'b1;  // Left only through reset
            end
        end
    end

endmodule

/* logic/need_levels.sv */
`timescale 1ns/100ps

`include "pet_config.svh"

module need_levels (
    input  logic               clk,
    input  logic               btn_reset,
    input  pet_pkg::feed_cmd_t cmd,
    input  logic               test_mode,
    output pet_pkg::levels_t   levels
);
    import pet_pkg::*;

    typedef logic [6:0] timer_t;

    // Last timer count of each decay period, indexed by need_t
    localparam timer_t DECAY_LAST [NEED_COUNT] = '{
        timer_t'(`PET_DECAY_HEALTH - 1),
        timer_t'(`PET_DECAY_ENERGY - 1),
        timer_t'(`PET_DECAY_HUNGER - 1),
        timer_t'(`PET_DECAY_FUN - 1)
    };

    localparam level_t LEVEL_MAX   = level_t'(`PET_LEVEL_MAX);
    localparam level_t LEVEL_START = level_t'(`PET_LEVEL_START);
    localparam level_t LEVEL_ONE   = level_t'(1);

    level_t                lvl   [NEED_COUNT];
    timer_t                timer [NEED_COUNT];
    logic [NEED_COUNT-1:0] wrap;  // Period ends this cycle
    logic [NEED_COUNT-1:0] hit;   // Command addresses this need

    // Level after a feeding command
    function automatic level_t fed_level(input level_t cur, input logic toggle);
        level_t next;
        if (toggle) begin
            next = (cur == LEVEL_ONE) ? LEVEL_MAX : LEVEL_ONE;  // Test mode 1 <-> max
        end else if (cur >= LEVEL_MAX) begin
            next = LEVEL_MAX;
        end else begin
            next = cur + LEVEL_ONE;
        end
        return next;
    endfunction

    always_comb begin
        for (int i = 0; i < NEED_COUNT; i++) begin
            wrap[i] = !test_mode && (timer[i] == DECAY_LAST[i]);
            hit[i]  = cmd.valid && (int'(cmd.need) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (btn_reset) begin
            for (int i = 0; i < NEED_COUNT; i++) begin
                lvl[i]   <= LEVEL_START;
                timer[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NEED_COUNT; i++) begin
                // Timers hold in test mode
                if (!test_mode) begin
                    timer[i] <= wrap[i] ? '0 : timer[i] + timer_t'(1);
                end

                // A command wins over the decay step
                if (hit[i]) begin
                    lvl[i] <= fed_level(lvl[i], cmd.toggle);
                end else if (wrap[i] && (lvl[i] != '0)) begin
                    lvl[i] <= lvl[i] - LEVEL_ONE;  // Floors at 0
                end
            end
        end
    end

    always_comb begin
        levels.health = lvl[NEED_HEALTH];
        levels.energy = lvl[NEED_ENERGY];
        levels.hunger = lvl[NEED_HUNGER];
        levels.fun    = lvl[NEED_FUN];
    end

endmodule

/* logic/status_display.sv */
`timescale 1ns/100ps

`include "pet_config.svh"

module status_display (
    input  logic                 clk,
    input  logic                 btn_reset,
    input  pet_pkg::need_t       sel,
    input  pet_pkg::levels_t     levels,
    output display_pkg::status_t status
);
    import pet_pkg::*;
    import display_pkg::*;

    localparam level_t LEVEL_START = level_t'(`PET_LEVEL_START);
    localparam level_t HAPPY_MIN   = level_t'(`PET_HAPPY_MIN);

    // Same word the first load after reset produces
    localparam status_t STATUS_RESET = '{
        happy: (LEVEL_START >= HAPPY_MIN),
        need:  NEED_HEALTH,
        seg:   level_to_seg(LEVEL_START)
    };

    level_t  cur_level;    // Level of the selected need
    status_t next_status;

    always_comb begin
        case (sel)
            NEED_HEALTH: cur_level = levels.health;
            NEED_ENERGY: cur_level = levels.energy;
            NEED_HUNGER: cur_level = levels.hunger;
            default:     cur_level = levels.fun;
        endcase
    end

    always_comb begin
        next_status.happy = (cur_level >= HAPPY_MIN);
        next_status.need  = sel;
        next_status.seg   = level_to_seg(cur_level);
    end

    always_ff @(posedge clk) begin
        if (btn_reset) begin
            status <= STATUS_RESET;
        end else begin
            status <= next_status;
        end
    end

endmodule

/* logic/pet_top.sv */
`timescale 1ns/100ps

module pet_top (
    input  logic                 clk,
    input  logic                 btn_reset,
    input  logic                 btn_health,
    input  logic                 btn_energy,
    input  logic                 btn_hunger,
    input  logic                 btn_fun,
    input  logic                 btn_test,
    input  logic                 sleep_ok,
    output display_pkg::status_t status,
    output logic                 test_led
);
    import pet_pkg::*;

    need_t     sel;        // Need on display
    feed_cmd_t cmd;        // Feed pulse to the level bank
    levels_t   levels;     // All current levels
    logic      test_mode;

    need_select u_need_select (
        .clk        (clk),
        .btn_reset  (btn_reset),
        .btn_health (btn_health),
        .btn_energy (btn_energy),
        .btn_hunger (btn_hunger),
        .btn_fun    (btn_fun),
        .btn_test   (btn_test),
        .sleep_ok   (sleep_ok),
        .sel        (sel),
        .cmd        (cmd),
        .test_mode  (test_mode)
    );

    need_levels u_need_levels (
        .clk       (clk),
        .btn_reset (btn_reset),
        .cmd       (cmd),
        .test_mode (test_mode),
        .levels    (levels)
    );

    status_display u_status_display (
        .clk       (clk),
        .btn_reset (btn_reset),
        .sel       (sel),
        .levels    (levels),
        .status    (status)
    );

    assign test_led = test_mode;

endmodule

/* sim/pet_sva.sv */
`timescale 1ns/100ps

`include "pet_config.svh"

module pet_sva (
    input logic                 clk,
    input logic                 btn_reset,
    input logic                 btn_test,
    input display_pkg::status_t status,
    input logic                 test_led
);
    import pet_pkg::*;
    import display_pkg::*;

    // Face for the level whose digit is shown
    function automatic logic seg_is_happy(input seg_t seg);
        logic happy;
        happy = 1'b0;
        for (int l = 0; l <= `PET_LEVEL_MAX; l++) begin
            if (level_to_seg(level_t'(l)) == seg) begin
                happy = (l >= `PET_HAPPY_MIN);
            end
        end
        return happy;
    endfunction

    led_needs_test: assert property (
        @(posedge clk) disable iff (btn_reset)
        $rose(test_led) |-> $past(btn_test)
    ) else $error("test_led rose without btn_test on the previous cycle");

    seg_not_blank: assert property (
        @(posedge clk) disable iff (btn_reset)
        status.seg != SEG_BLANK
    ) else $error("status.seg is blank");

    happy_matches_seg: assert property (
        @(posedge clk) disable iff (btn_reset)
        status.happy == seg_is_happy(status.seg)
    ) else $error("status.happy disagrees with status.seg");

endmodule

bind pet_top pet_sva u_pet_sva (
    .clk       (clk),
    .btn_reset (btn_reset),
    .btn_test  (btn_test),
    .status    (status),
    .test_led  (test_led)
);

/* sim/pet_tb.sv */
`timescale 1ns/100ps

`include "pet_config.svh"

module pet_tb;
    import pet_pkg::*;
    import display_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int TEST_CYCLES    = RESET_CYCLES + 15 + 15 + 605 + 110 + RANDOM_CYCLES + 15;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 500;  // Summed tests plus margin

    localparam logic [15:0] LFSR_SEED = 16'd42619;

    // Button masks for drive_cycle
    localparam logic [4:0] BTN_NONE   = 5'b00000;
    localparam logic [4:0] BTN_HEALTH = 5'b00001;
    localparam logic [4:0] BTN_ENERGY = 5'b00010;
    localparam logic [4:0] BTN_HUNGER = 5'b00100;
    localparam logic [4:0] BTN_FUN    = 5'b01000;
    localparam logic [4:0] BTN_TEST   = 5'b10000;

    localparam level_t LEVEL_MAX   = level_t'(`PET_LEVEL_MAX);
    localparam level_t LEVEL_START = level_t'(`PET_LEVEL_START);

    logic    clk = 1'b0;
    logic    btn_reset;
    logic    btn_health;
    logic    btn_energy;
    logic    btn_hunger;
    logic    btn_fun;
    logic    btn_test;
    logic    sleep_ok;
    status_t status;
    logic    test_led;

    logic        sleep_level;  // Value put on sleep_ok by drive_cycle
    logic [15:0] lfsr;
    int          error_count = 0;
    int          errors_before = 0;
    int          test_count = 0;
    int          test_failed = 0;

    // Reference model state
    logic       model_ready = 1'b0;
    need_t      m_sel;
    logic       m_cmd_valid;
    need_t      m_cmd_need;
    logic       m_cmd_toggle;
    logic       m_test;
    level_t     m_lvl [4];
    int         m_timer [4];
    status_t    m_status;

    pet_top dut0 (
        .clk        (clk),
        .btn_reset  (btn_reset),
        .btn_health (btn_health),
        .btn_energy (btn_energy),
        .btn_hunger (btn_hunger),
        .btn_fun    (btn_fun),
        .btn_test   (btn_test),
        .sleep_ok   (sleep_ok),
        .status     (status),
        .test_led   (test_led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Standard digits, segment a in bit 0
    function automatic seg_t digit_seg(input level_t level);
        case (level)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            4'd10:   return 7'b1110111;  // Shown as A
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic int decay_period(input int need);
        case (need)
            0:       return `PET_DECAY_HEALTH;
            1:       return `PET_DECAY_ENERGY;
            2:       return `PET_DECAY_HUNGER;
            default: return `PET_DECAY_FUN;
        endcase
    endfunction

    function automatic level_t after_feed(input level_t cur, input logic toggle);
        if (toggle) begin
            return (cur == 4'd1) ? LEVEL_MAX : 4'd1;
        end
        return (cur < LEVEL_MAX) ? cur + 4'd1 : LEVEL_MAX;
    endfunction

    function automatic status_t expected_status(input need_t sel, input level_t level);
        status_t s;
        s.happy = (level >= `PET_HAPPY_MIN);
        s.need  = sel;
        s.seg   = digit_seg(level);
        return s;
    endfunction

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    // Model registers, updated with the inputs seen at each edge
    always @(posedge clk) begin : model_step
        logic [3:0] req;
        logic       press;
        need_t      pnd;
        logic       wrap;
        logic       hit;
        status_t    nxt;
        int         i;

        nxt   = expected_status(m_sel, m_lvl[int'(m_sel)]);
        req   = {btn_fun, btn_hunger, btn_energy & sleep_ok, btn_health};
        press = |req;
        pnd   = NEED_HEALTH;
        for (i = 3; i >= 0; i--) begin
            if (req[i]) begin
                pnd = need_t'(i);  // Lowest index wins
            end
        end
        if (btn_reset) begin
            m_sel       = NEED_HEALTH;
            m_cmd_valid = 1'b0;
            m_test      = 1'b0;
            for (i = 0; i < 4; i++) begin
                m_lvl[i]   = LEVEL_START;
                m_timer[i] = 0;
            end
            nxt = expected_status(NEED_HEALTH, LEVEL_START);
        end else begin
            for (i = 0; i < 4; i++) begin
                wrap = !m_test && (m_timer[i] == decay_period(i) - 1);
                hit  = m_cmd_valid && (int'(m_cmd_need) == i);
                if (!m_test) begin
                    m_timer[i] = wrap ? 0 : m_timer[i] + 1;
                end
                if (hit) begin
                    m_lvl[i] = after_feed(m_lvl[i], m_cmd_toggle);
                end else if (wrap && (m_lvl[i] != 4'd0)) begin
                    m_lvl[i] = m_lvl[i] - 4'd1;
                end
            end
            m_cmd_valid  = press && (pnd == m_sel);
            m_cmd_need   = pnd;
            m_cmd_toggle = m_test;
            if (press) begin
                m_sel = pnd;
            end
            if (btn_test) begin
                m_test = 1'b1;
            end
        end
        m_status    = nxt;
        model_ready = 1'b1;
    end

    // Mid-cycle comparison against the model
    always @(negedge clk) begin : compare
        if (model_ready) begin
            if (status !== m_status) begin
                $display("mismatch at %0d ns: status expected %h, got %h",
                         $time, m_status, status);
                error_count++;
            end
            if (test_led !== m_test) begin
                $display("mismatch at %0d ns: test_led expected %b, got %b",
                         $time, m_test, test_led);
                error_count++;
            end
        end
    end

    task automatic drive_cycle(input logic [4:0] btns);
        @(posedge clk);
        #2;
        btn_health = btns[0];
        btn_energy = btns[1];
        btn_hunger = btns[2];
        btn_fun    = btns[3];
        btn_test   = btns[4];
        sleep_ok   = sleep_level;
    endtask

    task automatic press(input logic [4:0] btns);
        drive_cycle(btns);
        drive_cycle(BTN_NONE);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle(BTN_NONE);
    endtask

    task automatic apply_reset();
        btn_reset  = 1'b1;
        btn_health = 1'b0;
        btn_energy = 1'b0;
        btn_hunger = 1'b0;
        btn_fun    = 1'b0;
        btn_test   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        btn_reset = 1'b0;
    endtask

    task automatic expect_display(input logic happy, input need_t need, input level_t level,
                                  input string what);
        status_t exp;
        exp.happy = happy;
        exp.need  = need;
        exp.seg   = digit_seg(level);
        if (status !== exp) begin
            $display("mismatch at %0d ns: status (%s) expected %h, got %h",
                     $time, what, exp, status);
            error_count++;
        end
    endtask

    task automatic expect_led(input logic value, input string what);
        if (test_led !== value) begin
            $display("mismatch at %0d ns: test_led (%s) expected %b, got %b",
                     $time, what, value, test_led);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            test_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    task automatic check_reset_state();
        expect_display(1'b1, NEED_HEALTH, LEVEL_START, "after reset");
        expect_led(1'b0, "after reset");
        finish_test("after_reset");
    endtask

    task automatic feed_health();
        press(BTN_FUN);
        repeat (5) drive_cycle(BTN_HEALTH);  // Select, then four feeds
        idle(4);
        expect_display(1'b1, NEED_HEALTH, LEVEL_MAX, "health at max");
        finish_test("feed_health");
    endtask

    task automatic gate_energy();
        sleep_level = 1'b0;
        repeat (3) press(BTN_ENERGY);
        idle(3);
        expect_display(1'b1, NEED_HEALTH, LEVEL_MAX, "energy ignored");
        sleep_level = 1'b1;
        press(BTN_ENERGY);
        idle(2);
        expect_display(1'b1, NEED_ENERGY, LEVEL_START, "energy selected");
        sleep_level = 1'b0;
        finish_test("energy_gate");
    endtask

    task automatic idle_decay();
        press(BTN_FUN);
        idle(600);
        expect_display(1'b0, NEED_FUN, 4'd0, "fun decayed");
        finish_test("decay");
    endtask

    task automatic toggle_in_test_mode();
        apply_reset();
        press(BTN_TEST);
        idle(1);
        expect_led(1'b1, "test mode on");
        press(BTN_HUNGER);
        press(BTN_HUNGER);
        idle(3);
        expect_display(1'b0, NEED_HUNGER, 4'd1, "hunger toggled low");
        press(BTN_HUNGER);
        idle(3);
        expect_display(1'b1, NEED_HUNGER, LEVEL_MAX, "hunger toggled high");
        idle(80);  // Longer than the hunger period
        expect_display(1'b1, NEED_HUNGER, LEVEL_MAX, "hunger frozen");
        finish_test("test_mode");
    endtask

    task automatic run_random();
        logic [4:0] mask;
        logic       bit_a;
        logic       bit_b;
        int         c;
        int         b;
        apply_reset();
        for (c = 0; c < RANDOM_CYCLES; c++) begin
            mask = BTN_NONE;
            for (b = 0; b < 4; b++) begin
                take_bit(bit_a);
                take_bit(bit_b);
                mask[b] = bit_a & bit_b;  // Strobe one cycle in four
            end
            take_bit(bit_a);
            sleep_level = bit_a;
            if (c == RANDOM_CYCLES / 2) begin
                mask[4] = 1'b1;  // Second half in test mode
            end
            drive_cycle(mask);
        end
        sleep_level = 1'b0;
        idle(3);
        expect_led(1'b1, "random end");
        finish_test("random");
    endtask

    initial begin : main
        btn_reset   = 1'b1;
        btn_health  = 1'b0;
        btn_energy  = 1'b0;
        btn_hunger  = 1'b0;
        btn_fun     = 1'b0;
        btn_test    = 1'b0;
        sleep_ok    = 1'b0;
        sleep_level = 1'b0;
        lfsr        = LFSR_SEED;
        apply_reset();
        check_reset_state();
        feed_health();
        gate_energy();
        idle_decay();
        toggle_in_test_mode();
        run_random();
        $display("tests %0d, failed %0d, errors %0d", test_count, test_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/pet_pkg.sv
logic/display_pkg.sv
logic/need_select.sv
logic/need_levels.sv
logic/status_display.sv
logic/pet_top.sv
sim/pet_sva.sv
sim/pet_tb.sv

/* Makefile */
TOP := pet_tb
RTL := logic/pet_pkg.sv logic/display_pkg.sv logic/need_select.sv \
       logic/need_levels.sv logic/status_display.sv logic/pet_top.sv

.PHONY: all lint sim clean

all: sim

# RTL only, full warning set
lint:
	verilator --lint-only -Wall +incdir+logic $(RTL) --top-module pet_top

# Build and run; pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
